/* fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Program counter value after reset.
`define FETCH_BOOT_VECTOR 32'hBFC00000

// The SRAM holds 2**FETCH_SRAM_DEPTH_LOG2 words and aliases above that.
`define FETCH_SRAM_DEPTH_LOG2 8

// Cycles the SRAM waits before it returns a word, on top of the first one.
`define FETCH_SRAM_WAIT 2

`endif

/* fetchPkg.sv */
package fetchPkg;

    // Primary opcode field, bits [31:26] of an instruction word.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_OTHER   = 6'h3f
    } opcodeT;

    // Read sequencer of the instruction SRAM.
    typedef enum logic [1:0] {
        SRAM_IDLE = 2'd0,
        SRAM_WAIT = 2'd1,
        SRAM_DONE = 2'd2
    } sramStateT;

endpackage

/* instructionSram.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module instructionSram
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] address,
    input  logic        readEn,
    output logic [31:0] data,
    output logic        valid,

    input  logic        loadEn,
    input  logic [31:0] loadAddress,
    input  logic [31:0] loadData
);

    localparam int depthLog2 = `FETCH_SRAM_DEPTH_LOG2;
    localparam int waitCycles = `FETCH_SRAM_WAIT;
    localparam int countWidth = (waitCycles > 1) ? $clog2(waitCycles) : 1;

    logic [31:0]           memory [2**depthLog2];
    sramStateT             state;
    logic [depthLog2-1:0]  readIndex;
    logic [countWidth-1:0] waitCount;
    logic                  accept;

    // Requests are taken when idle, or in the cycle a word is handed back.
    assign accept = readEn && (state != SRAM_WAIT);
    assign valid = state == SRAM_DONE;
    assign data = memory[readIndex];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            memory[loadAddress[depthLog2+1:2]] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            readIndex <= address[depthLog2+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SRAM_IDLE;
            waitCount <= '0;
        end else if (accept) begin
            if (waitCycles == 0) begin
                state <= SRAM_DONE;
            end else begin
                state <= SRAM_WAIT;
                waitCount <= countWidth'(waitCycles - 1);
            end
        end else begin
            case (state)
                SRAM_WAIT: begin
                    if (waitCount == '0) begin
                        state <= SRAM_DONE;
                    end else begin
                        waitCount <= waitCount - 1'b1;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    // Back-to-back words only happen with zero wait states.
    singleCycleValid: assert property (
        @(posedge clk) disable iff (reset)
        (valid && (waitCycles != 0 || !readEn)) |=> !valid
    );

endmodule

/* jumpPredecoder.sv */
`timescale 1ns/1ps

module jumpPredecoder
    import fetchPkg::*;
(
    input  logic [31:0] instruction,
    input  logic [31:0] fetchPC,
    input  logic        bubble,

    input  logic        redirect,
    input  logic [31:0] redirectAddress,

    output logic        absJump,
    output logic [31:0] absJumpAddress
);

    opcodeT      opcode;
    logic        isJumpWord;
    logic [31:0] sequentialPC;
    logic [31:0] jumpTarget;

    assign opcode = opcodeT'(instruction[31:26]);

    always_comb begin
        case (opcode)
            OP_J, OP_JAL: isJumpWord = 1'b1;
            default:      isJumpWord = 1'b0;
        endcase
    end

    // J-type targets stay in the 256 MB region of the delay slot.
    assign sequentialPC = fetchPC + 32'd4;
    assign jumpTarget = {sequentialPC[31:28], instruction[25:0], 2'b00};

    // Only a delivered word may jump. An outside redirect overrides it.
    assign absJump = redirect || (!bubble && isJumpWord);
    assign absJumpAddress = redirect ? redirectAddress : jumpTarget;

endmodule

/* instructionFetch.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module instructionFetch
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        absJump,
    input  logic [31:0] absJumpAddress,

    input  logic        stall,
    input  logic        exception,

    output logic [31:0] outputPC,
    output logic [31:0] instruction,
    output logic        bubble,
    output logic        adel,
    output logic        isDelaySlot,

    output logic [31:0] sramAddress,
    output logic        sramReadEn,
    input  logic [31:0] sramData,
    input  logic        sramValid
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic        busy;
    logic        canSendNewCommand;
    logic        inException;

    logic        pendingJump;
    logic        pendingJumpNext;
    logic [31:0] pendingJumpAddress;
    logic        pendingException;
    logic        pendingExceptionNext;

    // A new read may go out once the previous one has returned its word.
    assign canSendNewCommand = sramValid || !busy;
    assign inException = exception || pendingException;

    assign outputPC = pc;
    assign sramAddress = pcNext;
    assign adel = pc[1:0] != 2'b00;

    // A misaligned fetch never reads the SRAM, so it hands on a NOP
    // instead of whatever word the SRAM returned last.
    assign instruction = adel ? 32'h0000_0000 : sramData;

    // A beat goes out when the word has arrived, or at once for a misaligned PC.
    assign bubble = !(canSendNewCommand && !stall && !inException && (sramValid || adel));

    always_comb begin
        pcNext = pc;
        sramReadEn = 1'b0;
        isDelaySlot = 1'b0;
        pendingJumpNext = pendingJump;
        pendingExceptionNext = pendingException;

        if (!canSendNewCommand) begin
            // A read is in flight. Keep whatever arrives until the word is back.
            pendingJumpNext = pendingJump || absJump;
            pendingExceptionNext = inException;
        end else if (inException && !pendingJump && !absJump) begin
            // Park on the exception with no reads until a jump or redirect.
            pendingExceptionNext = 1'b1;
        end else if (stall) begin
            // Hold the PC and read it again, so the word is fresh after the stall.
            pendingJumpNext = pendingJump || absJump;
            sramReadEn = pc[1:0] == 2'b00;
        end else begin
            pendingJumpNext = 1'b0;
            pendingExceptionNext = 1'b0;
            if (pendingJump) begin
                pcNext = pendingJumpAddress;
                isDelaySlot = 1'b1;
            end else if (absJump) begin
                pcNext = absJumpAddress;
                isDelaySlot = 1'b1;
            end else if (!bubble) begin
                pcNext = pc + 32'd4;
            end
            // Misaligned targets are delivered without touching the SRAM.
            sramReadEn = pcNext[1:0] == 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FETCH_BOOT_VECTOR;
            busy <= 1'b0;
            pendingJump <= 1'b0;
            pendingException <= 1'b0;
        end else begin
            pc <= pcNext;
            if (canSendNewCommand) begin
                busy <= sramReadEn;
            end
            pendingJump <= pendingJumpNext;
            pendingException <= pendingExceptionNext;
        end
    end

    // The newest jump that is not taken right away is the one to follow.
    always_ff @(posedge clk) begin
        if (absJump && pendingJumpNext) begin
            pendingJumpAddress <= absJumpAddress;
        end
    end

    // Every word the SRAM hands back answers a read that is still outstanding.
    readReturnsWhileBusy: assert property (
        @(posedge clk) disable iff (reset)
        sramValid |-> busy
    );

endmodule

/* fetchTop.sv */
`timescale 1ns/1ps

module fetchTop
    import fetchPkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        stall,
    input  logic        exception,
    input  logic        redirect,
    input  logic [31:0] redirectAddress,

    input  logic        loadEn,
    input  logic [31:0] loadAddress,
    input  logic [31:0] loadData,

    output logic [31:0] fetchPC,
    output logic [31:0] fetchInstruction,
    output logic        bubble,
    output logic        adel,
    output logic        isDelaySlot
);

    logic        absJump;
    logic [31:0] absJumpAddress;
    logic [31:0] sramAddress;
    logic        sramReadEn;
    logic [31:0] sramData;
    logic        sramValid;

    instructionFetch fetch (
        .clk            (clk),
        .reset          (reset),
        .absJump        (absJump),
        .absJumpAddress (absJumpAddress),
        .stall          (stall),
        .exception      (exception),
        .outputPC       (fetchPC),
        .instruction    (fetchInstruction),
        .bubble         (bubble),
        .adel           (adel),
        .isDelaySlot    (isDelaySlot),
        .sramAddress    (sramAddress),
        .sramReadEn     (sramReadEn),
        .sramData       (sramData),
        .sramValid      (sramValid)
    );

    jumpPredecoder predecoder (
        .instruction     (fetchInstruction),
        .fetchPC         (fetchPC),
        .bubble          (bubble),
        .redirect        (redirect),
        .redirectAddress (redirectAddress),
        .absJump         (absJump),
        .absJumpAddress  (absJumpAddress)
    );

    instructionSram sram (
        .clk         (clk),
        .reset       (reset),
        .address     (sramAddress),
        .readEn      (sramReadEn),
        .data        (sramData),
        .valid       (sramValid),
        .loadEn      (loadEn),
        .loadAddress (loadAddress),
        .loadData    (loadData)
    );

endmodule

/* fetchTb.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchTb
    import fetchPkg::*;
();

    localparam int numBeats = 400;
    localparam int depthLog2 = `FETCH_SRAM_DEPTH_LOG2;
    localparam int beatCycles = `FETCH_SRAM_WAIT + 1;
    localparam int watchdogCycles = numBeats * beatCycles * 4 + 1000;

    localparam int testBoot = 0;
    localparam int testSequential = 1;
    localparam int testJump = 2;
    localparam int testStall = 3;
    localparam int testException = 4;
    localparam int testOverride = 5;
    localparam int numTests = 6;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        exception;
    logic        redirect;
    logic [31:0] redirectAddress;
    logic        loadEn;
    logic [31:0] loadAddress;
    logic [31:0] loadData;
    logic [31:0] fetchPC;
    logic [31:0] fetchInstruction;
    logic        bubble;
    logic        adel;
    logic        isDelaySlot;

    logic [31:0] programWords [2**depthLog2];
    int          testChecks [numTests];
    int          testFails [numTests];
    int          beatsSeen;

    fetchTop uut (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .exception        (exception),
        .redirect         (redirect),
        .redirectAddress  (redirectAddress),
        .loadEn           (loadEn),
        .loadAddress      (loadAddress),
        .loadData         (loadData),
        .fetchPC          (fetchPC),
        .fetchInstruction (fetchInstruction),
        .bubble           (bubble),
        .adel             (adel),
        .isDelaySlot      (isDelaySlot)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic string testName(input int test);
        case (test)
            testBoot:       return "boot vector";
            testSequential: return "sequential fetch";
            testJump:       return "jump target";
            testStall:      return "stall";
            testException:  return "misaligned exception";
            default:        return "redirect override";
        endcase
    endfunction

    function automatic bit isJumpWord(input logic [31:0] word);
        return word[31:26] == OP_J || word[31:26] == OP_JAL;
    endfunction

    // J-type target from the region of the delay slot and the index shifted to a word address.
    function automatic logic [31:0] jumpTarget(input logic [31:0] pc, input logic [31:0] word);
        logic [31:0] slotPC;
        slotPC = pc + 32'd4;
        return {slotPC[31:28], word[25:0], 2'b00};
    endfunction

    function automatic logic [31:0] wordAt(input logic [31:0] pc);
        return programWords[pc[depthLog2+1:2]];
    endfunction

    task automatic compareValue(input int test, input logic [31:0] expected,
                                input logic [31:0] actual);
        testChecks[test]++;
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", testName(test), expected, actual);
            testFails[test]++;
        end
    endtask

    task automatic expectTrue(input int test, input bit condition, input string problem);
        testChecks[test]++;
        assert (condition) else begin
            $display("%s: %s at %0t ns", testName(test), problem, $time);
            testFails[test]++;
        end
    endtask

    // Roughly one word in eight is a J or JAL.
    task automatic makeProgram();
        logic [31:0] word;
        for (int i = 0; i < 2**depthLog2; i++) begin
            word = $urandom;
            if ($urandom_range(0, 7) == 0) begin
                word[31:26] = ($urandom_range(0, 1) == 0) ? OP_J : OP_JAL;
            end else if (isJumpWord(word)) begin
                word[31:26] = OP_SPECIAL;
            end
            programWords[i] = word;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 2**depthLog2; i++) begin
            @(negedge clk);
            loadEn = 1'b1;
            loadAddress = `FETCH_BOOT_VECTOR + 32'(i * 4);
            loadData = programWords[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    initial begin
        logic [31:0] expectedPC;
        logic [31:0] overrideTarget;
        int          nextTest;
        int          exceptionCycles;
        int          idleCycles;
        int          overrideDelay;
        int          overrideWait;
        int          checks;
        int          errors;
        bit          parked;
        bit          wasParked;
        bit          overrideArmed;
        bit          aligned;
        bit          jumpWord;

        void'($urandom(32'h9f4d4ccf));
        reset = 1'b1;
        stall = 1'b1;
        exception = 1'b0;
        redirect = 1'b0;
        redirectAddress = '0;
        loadEn = 1'b0;
        loadAddress = '0;
        loadData = '0;
        beatsSeen = 0;
        makeProgram();

        repeat (10) @(negedge clk);
        reset = 1'b0;
        // The boot read waits under stall until the program is in place.
        loadProgram();

        expectedPC = `FETCH_BOOT_VECTOR;
        nextTest = testBoot;
        parked = 1'b0;
        overrideArmed = 1'b0;
        overrideDelay = 0;
        overrideWait = 0;
        exceptionCycles = 0;
        idleCycles = 0;

        while (beatsSeen < numBeats) begin
            @(negedge clk);
            stall = $urandom_range(0, 99) < 20;
            exception = 1'b0;
            redirect = 1'b0;
            wasParked = parked;
            if (parked) begin
                if (exceptionCycles > 0) begin
                    exception = 1'b1;
                    exceptionCycles--;
                end else if (idleCycles > 0) begin
                    idleCycles--;
                end else begin
                    // A single redirect cycle ends the exception.
                    redirect = 1'b1;
                    redirectAddress = $urandom & 32'hffff_fffc;
                    expectedPC = redirectAddress;
                    nextTest = testException;
                    parked = 1'b0;
                end
            end else if (overrideArmed) begin
                // Without stalls the J word's beat lands beatCycles after the last beat.
                stall = 1'b0;
                overrideWait++;
                if (overrideWait >= overrideDelay) begin
                    redirect = 1'b1;
                    redirectAddress = overrideTarget;
                end
            end

            #10;
            if (stall) begin
                expectTrue(testStall, bubble, "beat delivered while stall was high");
            end
            if (wasParked) begin
                expectTrue(testException, bubble, "beat delivered during an exception");
            end

            if (!bubble) begin
                aligned = expectedPC[1:0] == 2'b00;
                jumpWord = aligned && isJumpWord(wordAt(expectedPC));
                compareValue(nextTest, expectedPC, fetchPC);
                compareValue(testException, {31'd0, !aligned}, {31'd0, adel});
                if (aligned) begin
                    compareValue(testSequential, wordAt(expectedPC), fetchInstruction);
                end
                compareValue(overrideArmed ? testOverride : testJump,
                             {31'd0, overrideArmed || jumpWord}, {31'd0, isDelaySlot});

                if (overrideArmed) begin
                    expectTrue(testOverride, overrideWait == beatCycles,
                               "the J word arrived off the sequential beat timing");
                    expectedPC = overrideTarget;
                    nextTest = testOverride;
                    overrideArmed = 1'b0;
                end else if (!aligned) begin
                    parked = 1'b1;
                    exceptionCycles = $urandom_range(1, 3);
                    idleCycles = $urandom_range(0, 3);
                end else if (jumpWord) begin
                    expectedPC = jumpTarget(expectedPC, wordAt(expectedPC));
                    nextTest = testJump;
                end else begin
                    expectedPC = expectedPC + 32'd4;
                    nextTest = testSequential;
                end

                // Sometimes redirect over the J word that comes next, now and then misaligned.
                // The redirect starts during its read or only in its own beat cycle.
                if (!parked && expectedPC[1:0] == 2'b00 && isJumpWord(wordAt(expectedPC))
                        && $urandom_range(0, 2) == 0) begin
                    overrideArmed = 1'b1;
                    overrideDelay = $urandom_range(1, beatCycles);
                    overrideWait = 0;
                    overrideTarget = $urandom;
                    if ($urandom_range(0, 2) != 0) begin
                        overrideTarget[1:0] = 2'b00;
                    end
                end
                beatsSeen++;
            end
        end

        checks = 0;
        errors = 0;
        for (int t = 0; t < numTests; t++) begin
            $display("%s: %0d checks, %0d errors", testName(t), testChecks[t], testFails[t]);
            checks += testChecks[t];
            errors += testFails[t];
        end
        $display("Summary: %0d beats, %0d checks, %0d errors", beatsSeen, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: %0d of %0d beats arrived within %0d cycles",
                 beatsSeen, numBeats, watchdogCycles);
        $display("Checks failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
fetchPkg.sv
instructionSram.sv
jumpPredecoder.sv
instructionFetch.sv
fetchTop.sv
fetchTb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - .
    files:
      - fetchPkg.sv
      - instructionSram.sv
      - jumpPredecoder.sv
      - instructionFetch.sv
      - fetchTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetchTb.sv
